//--- build.f
+incdir+.
cpuPkg.sv
memBank.sv
regFile.sv
instrDecoder.sv
hazardUnit.sv
executeStage.sv
cpu.sv
tbCpu.sv

//--- Bender.yml
package:
  name: cpu

export_include_dirs:
  - .

sources:
  - files:
      - cpuPkg.sv
      - memBank.sv
      - regFile.sv
      - instrDecoder.sv
      - hazardUnit.sv
      - executeStage.sv
      - cpu.sv
  - target: test
    files:
      - tbCpu.sv

//--- tbCpu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tbCpu import cpuPkg::*; ();

  localparam int clkPeriod    = 40;
  localparam int resetCycles  = 8;
  localparam int testCount    = 6;
  localparam int testCycleCap = 250;
  // Six tests with double margin
  localparam int maxCycles    = testCount * testCycleCap * 2;

  logic    clk;
  logic    rstN;
  logic    run;
  logic    progWrEn;
  wordT    progAddr;
  wordT    progData;
  regAddrT dbgAddr;
  logic    hlt;
  wordT    pc;
  wordT    dbgData;

  int          errorCount = 0;
  int          cycleCount = 0;
  logic [31:0] rngState   = 32'hf142;

  // Program image and reference machine state
  wordT  prog [$];
  wordT  refRegs [`CPU_REG_COUNT];
  flagsT refFlags;
  wordT  refMem [wordT];

  cpu cpu_i (
    .clk      (clk),
    .rstN     (rstN),
    .run      (run),
    .progWrEn (progWrEn),
    .progAddr (progAddr),
    .progData (progData),
    .dbgAddr  (dbgAddr),
    .hlt      (hlt),
    .pc       (pc),
    .dbgData  (dbgData)
  );

  initial clk = 1'b0;
  always #(clkPeriod / 2) clk = ~clk;

  // Hard stop for the whole run
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= maxCycles) begin
      $display("Timeout, run went past %0d cycles", maxCycles);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Encoding and ISA reference model
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic wordT sext8(input logic [7:0] v);
    return {{8{v[7]}}, v};
  endfunction

  function automatic wordT sext4(input logic [3:0] v);
    return {{12{v[3]}}, v};
  endfunction

  function automatic wordT encAlu(input opcodeE op, input int rd, input int rs, input int rt);
    return {op, rd[3:0], rs[3:0], rt[3:0]};
  endfunction

  function automatic wordT encLdi(input int rd, input logic [7:0] imm);
    return {LDI, rd[3:0], imm};
  endfunction

  function automatic wordT encMem(input opcodeE op, input int rd, input int rs, input int off);
    return {op, rd[3:0], rs[3:0], off[3:0]};
  endfunction

  // Offset counted in instructions
  function automatic wordT encBranch(input branchCondE c, input int off);
    return {B, c, off[8:0]};
  endfunction

  function automatic wordT aluModel(input opcodeE op, input wordT a, input wordT b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      XOR:     return a ^ b;
      AND:     return a & b;
      SLL:     return a << b[3:0];
      SRL:     return a >> b[3:0];
      default: return '0;
    endcase
  endfunction

  // Z from all ALU ops
  // V and N only from add and sub
  function automatic flagsT flagModel(input opcodeE op, input wordT a, input wordT b,
                                      input wordT r, input flagsT f);
    flagsT nf;
    int    sa;
    int    sb;
    int    full;
    nf = f;
    sa = $signed(a);
    sb = $signed(b);
    if (op inside {ADD, SUB, XOR, AND, SLL, SRL}) begin
      nf.z = (r == '0);
    end
    if (op inside {ADD, SUB}) begin
      // Exact signed result, V when it does not fit in 16 bits
      full = (op == ADD) ? (sa + sb) : (sa - sb);
      nf.v = (full > 32767) || (full < -32768);
      nf.n = r[15];
    end
    return nf;
  endfunction

  function automatic logic condHolds(input branchCondE c, input flagsT f);
    case (c)
      NE:      return !f.z;
      EQ:      return f.z;
      GT:      return !f.z && !f.n;
      LT:      return f.n;
      GE:      return f.z || !f.n;
      LE:      return f.n || f.z;
      OV:      return f.v;
      default: return 1'b1;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Program builders that also step the reference model
  task automatic randByte(output logic [7:0] v);
    rngState = xorshift32(rngState);
    v = rngState[7:0];
  endtask

  task automatic emit(input wordT w);
    prog.push_back(w);
  endtask

  task automatic asmLdi(input int rd, input logic [7:0] imm);
    emit(encLdi(rd, imm));
    refRegs[rd] = sext8(imm);
  endtask

  task automatic asmAlu(input opcodeE op, input int rd, input int rs, input int rt);
    wordT a;
    wordT b;
    wordT r;
    a = refRegs[rs];
    b = refRegs[rt];
    r = aluModel(op, a, b);
    refFlags = flagModel(op, a, b, r, refFlags);
    refRegs[rd] = r;
    emit(encAlu(op, rd, rs, rt));
  endtask

  task automatic asmStore(input int rd, input int rs, input int off);
    wordT addr;
    addr = refRegs[rs] + sext4(off[3:0]);
    refMem[addr] = refRegs[rd];
    emit(encMem(SW, rd, rs, off));
  endtask

  task automatic asmLoad(input int rd, input int rs, input int off);
    wordT addr;
    addr = refRegs[rs] + sext4(off[3:0]);
    refRegs[rd] = refMem.exists(addr) ? refMem[addr] : 'x;
    emit(encMem(LW, rd, rs, off));
  endtask

  // Branch over one marker LDI
  // Marker lands only when the branch falls through
  task automatic asmSkip(input branchCondE c, input int markRd, input logic [7:0] markImm);
    emit(encBranch(c, 1));
    emit(encLdi(markRd, markImm));
    if (!condHolds(c, refFlags)) begin
      refRegs[markRd] = sext8(markImm);
    end
  endtask

  task automatic asmHalt();
    emit({HLT, 12'h000});
  endtask

  task automatic modelReset();
    for (int i = 0; i < `CPU_REG_COUNT; i++) begin
      refRegs[i] = '0;
    end
    refFlags = '0;
    refMem.delete();
    prog.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // DUT drivers and checks
  task automatic applyReset();
    @(posedge clk);
    #2;
    rstN     = 1'b0;
    run      = 1'b0;
    progWrEn = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #2;
    rstN = 1'b1;
  endtask

  task automatic loadProgram();
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      #2;
      progWrEn = 1'b1;
      progAddr = wordT'(i);
      progData = prog[i];
    end
    @(posedge clk);
    #2;
    progWrEn = 1'b0;
  endtask

  task automatic runUntilHalt(input string testName);
    int waited;
    waited = 0;
    @(posedge clk);
    #2;
    run = 1'b1;
    while (!hlt && waited < testCycleCap) begin
      @(negedge clk);
      waited++;
    end
    if (!hlt) begin
      $display("%s: hlt never rose within %0d cycles", testName, testCycleCap);
      errorCount++;
    end
  endtask

  task automatic checkValue(input string name, input wordT expected, input wordT actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  // Debug port read sampled mid-cycle
  task automatic checkReg(input string testName, input int idx, input wordT expected);
    @(posedge clk);
    #2;
    dbgAddr = idx[3:0];
    @(negedge clk);
    checkValue($sformatf("%s r%0d", testName, idx), expected, dbgData);
  endtask

  task automatic checkAllRegs(input string testName);
    for (int i = 0; i < `CPU_REG_COUNT; i++) begin
      checkReg(testName, i, refRegs[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  // Back-to-back dependencies hit EX/MEM, MEM/WB and write-through
  task automatic aluChainTest();
    logic [7:0] v0;
    logic [7:0] v1;
    logic [7:0] v2;
    logic [7:0] v3;
    applyReset();
    modelReset();
    randByte(v0);
    randByte(v1);
    randByte(v2);
    randByte(v3);
    asmLdi(0, v0);
    asmLdi(1, v1);
    asmLdi(2, v2);
    asmLdi(3, v3);
    asmAlu(ADD, 4, 1, 2);
    asmAlu(SUB, 5, 4, 0);
    asmAlu(XOR, 6, 5, 2);
    asmAlu(AND, 7, 6, 4);
    asmAlu(SLL, 8, 7, 3);
    asmAlu(SRL, 9, 8, 3);
    asmAlu(ADD, 10, 9, 6);
    asmAlu(SUB, 11, 10, 5);
    asmAlu(ADD, 12, 0, 11);
    asmHalt();
    loadProgram();
    runUntilHalt("aluChain");
    checkAllRegs("aluChain");
  endtask

  task automatic memoryTest();
    logic [7:0] v1;
    logic [7:0] v2;
    logic [7:0] base;
    applyReset();
    modelReset();
    randByte(v1);
    randByte(v2);
    randByte(base);
    // Keeps base plus offsets inside data memory
    base = 8'h40 | (base & 8'h1f);
    asmLdi(3, base);
    asmLdi(1, v1);
    asmLdi(2, v2);
    asmStore(1, 3, 0);
    asmStore(2, 3, 1);
    asmAlu(ADD, 4, 1, 2);
    // Store data forwarded from EX/MEM
    asmStore(4, 3, -1);
    asmLoad(5, 3, 0);
    asmLoad(6, 3, 1);
    // Load-use on rs
    asmAlu(ADD, 7, 6, 5);
    asmLoad(8, 3, -1);
    asmAlu(SUB, 9, 8, 1);
    // Load-use on store data
    asmLoad(10, 3, 1);
    asmStore(10, 3, 2);
    asmLoad(11, 3, 2);
    asmAlu(XOR, 12, 11, 4);
    asmHalt();
    loadProgram();
    runUntilHalt("memory");
    checkAllRegs("memory");
  endtask

  // One flag setter and one branch per condition with markers in r8..r15
  task automatic branchTest();
    opcodeE     scOp [8];
    int         scA [8];
    int         scB [8];
    logic [7:0] mark;
    applyReset();
    modelReset();
    scOp = '{SUB, SUB, SUB, SUB, SUB, SUB, ADD, SUB};
    scA  = '{1, 1, 1, 3, 3, 1, 4, 1};
    scB  = '{2, 2, 3, 1, 1, 3, 4, 2};
    asmLdi(1, 8'd5);
    asmLdi(2, 8'd5);
    asmLdi(3, 8'd3);
    asmLdi(4, 8'd64);
    asmLdi(6, 8'd8);
    // r4 becomes 0x4000 so r4 plus r4 overflows
    asmAlu(SLL, 4, 4, 6);
    for (int c = 0; c < 8; c++) begin
      mark = c[7:0] + 8'd1;
      asmAlu(scOp[c], 7, scA[c], scB[c]);
      asmSkip(branchCondE'(c[2:0]), 8 + c, mark);
    end
    asmHalt();
    loadProgram();
    runUntilHalt("branch");
    checkAllRegs("branch");
  endtask

  // Logic ops touch only Z so V and N survive
  task automatic flagRuleTest();
    applyReset();
    modelReset();
    asmLdi(1, 8'd64);
    asmLdi(2, 8'd8);
    asmAlu(SLL, 1, 1, 2);
    asmAlu(ADD, 3, 1, 1);
    asmAlu(XOR, 4, 3, 3);
    asmSkip(OV, 5, 8'h01);
    asmSkip(EQ, 6, 8'h02);
    asmSkip(LT, 8, 8'h03);
    asmAlu(AND, 9, 3, 4);
    asmSkip(OV, 10, 8'h04);
    asmSkip(NE, 11, 8'h05);
    asmHalt();
    loadProgram();
    runUntilHalt("flagRule");
    checkAllRegs("flagRule");
  endtask

  task automatic haltTest();
    logic [7:0] v1;
    logic [7:0] v2;
    wordT       hltAddr;
    applyReset();
    modelReset();
    randByte(v1);
    randByte(v2);
    asmLdi(1, v1);
    asmLdi(2, v2);
    asmAlu(ADD, 3, 1, 2);
    hltAddr = wordT'(prog.size() * 2);
    asmHalt();
    // Past the halt and never committed
    emit(encLdi(4, 8'h55));
    emit(encLdi(1, 8'h11));
    loadProgram();
    runUntilHalt("halt");
    repeat (10) begin
      @(negedge clk);
      checkValue("halt hlt", 16'h0001, {15'b0, hlt});
      checkValue("halt pc", hltAddr + wordT'(2), pc);
    end
    checkAllRegs("halt");
  endtask

  task automatic resetTest();
    logic [7:0] v1;
    logic [7:0] v2;
    applyReset();
    modelReset();
    for (int i = 1; i <= 6; i++) begin
      asmLdi(i, 8'h10 + i[7:0]);
    end
    for (int k = 0; k < 12; k++) begin
      asmAlu(ADD, 1 + (k % 6), 1 + ((k + 1) % 6), 1 + ((k + 2) % 6));
    end
    asmHalt();
    loadProgram();
    @(posedge clk);
    #2;
    run = 1'b1;
    // Partway through with some registers already written
    repeat (12) @(negedge clk);
    checkValue("reset mid-run hlt", 16'h0000, {15'b0, hlt});
    @(posedge clk);
    #2;
    rstN = 1'b0;
    run  = 1'b0;
    @(negedge clk);
    checkValue("reset pc", 16'h0000, pc);
    for (int i = 0; i < `CPU_REG_COUNT; i++) begin
      checkReg("reset", i, 16'h0000);
    end
    @(posedge clk);
    #2;
    rstN = 1'b1;
    // Fresh program after the reset
    modelReset();
    randByte(v1);
    randByte(v2);
    asmLdi(1, v1);
    asmLdi(2, v2);
    asmAlu(SUB, 3, 1, 2);
    asmAlu(AND, 4, 3, 1);
    asmAlu(SRL, 5, 4, 2);
    asmHalt();
    loadProgram();
    runUntilHalt("reset reload");
    checkAllRegs("reset reload");
    // Reset after the halt drops the sticky hlt
    @(posedge clk);
    #2;
    rstN = 1'b0;
    run  = 1'b0;
    @(negedge clk);
    checkValue("reset after halt hlt", 16'h0000, {15'b0, hlt});
    checkValue("reset after halt pc", 16'h0000, pc);
    @(posedge clk);
    #2;
    rstN = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  initial begin
    rstN     = 1'b0;
    run      = 1'b0;
    progWrEn = 1'b0;
    progAddr = '0;
    progData = '0;
    dbgAddr  = '0;
    aluChainTest();
    memoryTest();
    branchTest();
    flagRuleTest();
    haltTest();
    resetTest();
    $display("Checks finished with %0d error(s)", errorCount);
    if (errorCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- cpu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  logic    run,
  // Program load, word addressed
  input  logic    progWrEn,
  input  wordT    progAddr,
  input  wordT    progData,
  input  regAddrT dbgAddr,
  output logic    hlt,
  output wordT    pc,
  output wordT    dbgData
);

  wordT pcQ;
  wordT pcNext;
  wordT imemAddr;
  wordT instrIf;
  wordT rsData;
  wordT rtData;
  wordT dmemRdData;
  wordT wbData;
  wordT branchTarget;

  ifIdT  ifId;
  idExT  idEx;
  idExT  idExNext;
  exMemT exMem;
  exMemT exMemNext;
  memWbT memWb;

  ctrlT       decCtrl;
  regAddrT    decRs;
  regAddrT    decRt;
  regAddrT    decRd;
  wordT       decImm;
  branchCondE decCond;

  fwdSelE fwdA;
  fwdSelE fwdB;
  logic   stall;
  logic   flush;
  logic   branchTaken;
  logic   holdIf;
  logic   hltQ;

  ////////////////////////////////////////////////////////////
  // IF
  // Loader owns the instruction memory while run is low
  assign imemAddr = run ? (pcQ >> 1) : progAddr;

  memBank #(.depth(`CPU_IMEM_DEPTH)) imem (
    .clk    (clk),
    .wrEn   (progWrEn && !run),
    .addr   (imemAddr),
    .wrData (progData),
    .rdData (instrIf)
  );

  // Load-use stall or HLT in decode freezes fetch
  assign holdIf = stall || decCtrl.halt;

  // Taken branch first, it also overrides the halt freeze
  always_comb begin
    if (branchTaken) begin
      pcNext = branchTarget;
    end else if (holdIf) begin
      pcNext = pcQ;
    end else begin
      pcNext = pcQ + wordT'(2);
    end
  end

  ////////////////////////////////////////////////////////////
  // ID
  instrDecoder dec (
    .instr (ifId.instr),
    .ctrl  (decCtrl),
    .rs    (decRs),
    .rt    (decRt),
    .rd    (decRd),
    .imm   (decImm),
    .cond  (decCond)
  );

  regFile rf (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddrA (decRs),
    .rdAddrB (decRt),
    .rdDataA (rsData),
    .rdDataB (rtData),
    .wrEn    (memWb.ctrl.regWrite && run),
    .wrAddr  (memWb.rd),
    .wrData  (wbData),
    .dbgAddr (dbgAddr),
    .dbgData (dbgData)
  );

  always_comb begin
    idExNext = '{ctrl: decCtrl, pc: ifId.pc, rsData: rsData, rtData: rtData,
                 imm: decImm, rs: decRs, rt: decRt, rd: decRd, cond: decCond};
    // Bubble on stall or flush
    if (stall || flush) begin
      idExNext.ctrl = '0;
    end
  end

  hazardUnit hz (
    .idEx        (idEx),
    .exMem       (exMem),
    .memWb       (memWb),
    .decRs       (decRs),
    .decRt       (decRt),
    .branchTaken (branchTaken),
    .fwdA        (fwdA),
    .fwdB        (fwdB),
    .stall       (stall),
    .flush       (flush)
  );

  ////////////////////////////////////////////////////////////
  // EX
  executeStage ex (
    .clk          (clk),
    .rstN         (rstN),
    .idEx         (idEx),
    .exResult     (exMem.result),
    .wbResult     (wbData),
    .fwdA         (fwdA),
    .fwdB         (fwdB),
    .exOut        (exMemNext),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .flags        ()
  );

  ////////////////////////////////////////////////////////////
  // MEM and WB
  memBank #(.depth(`CPU_DMEM_DEPTH)) dmem (
    .clk    (clk),
    .wrEn   (exMem.ctrl.memWrite && run),
    .addr   (exMem.result),
    .wrData (exMem.storeData),
    .rdData (dmemRdData)
  );

  assign wbData = memWb.ctrl.memToReg ? memWb.loadData : memWb.result;

  // Sticky once HLT commits
  assign hlt = hltQ || memWb.ctrl.halt;
  assign pc  = pcQ;

  // Whole pipeline holds while run is low
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcQ   <= '0;
      ifId  <= '0;
      idEx  <= '0;
      exMem <= '0;
      memWb <= '0;
      hltQ  <= 1'b0;
    end else if (run) begin
      pcQ <= pcNext;
      if (flush) begin
        ifId <= '0;
      end else if (!holdIf) begin
        ifId <= '{pc: pcQ, instr: instrIf};
      end
      idEx  <= idExNext;
      exMem <= exMemNext;
      memWb <= '{ctrl: exMem.ctrl, result: exMem.result,
                 loadData: dmemRdData, rd: exMem.rd};
      hltQ  <= hltQ || memWb.ctrl.halt;
    end
  end

  // Fetch steps and doubled branch offsets keep pc halfword aligned
  pcEven: assert property (@(posedge clk) disable iff (!rstN) !pcQ[0])
    else $error("Odd pc %h", pcQ);

endmodule

//--- executeStage.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module executeStage import cpuPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  idExT   idEx,
  // Forwarded values from EX/MEM and WB
  input  wordT   exResult,
  input  wordT   wbResult,
  input  fwdSelE fwdA,
  input  fwdSelE fwdB,
  output exMemT  exOut,
  output logic   branchTaken,
  output wordT   branchTarget,
  output flagsT  flags
);

  localparam int msb = `CPU_DATA_WIDTH - 1;
  localparam int shWidth = $clog2(`CPU_DATA_WIDTH);

  wordT opA;
  wordT opB;
  wordT aluRes;
  logic aluOvf;
  logic writeZ;
  logic writeVn;
  logic condMet;

  function automatic wordT fwdMux(
    input fwdSelE sel,
    input wordT   regVal,
    input wordT   exVal,
    input wordT   wbVal
  );
    case (sel)
      EXMEM:   return exVal;
      MEMWB:   return wbVal;
      default: return regVal;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////
  // ALU
  assign opA = fwdMux(fwdA, idEx.rsData, exResult, wbResult);
  assign opB = fwdMux(fwdB, idEx.rtData, exResult, wbResult);

  always_comb begin
    aluRes = '0;
    aluOvf = 1'b0;
    case (idEx.ctrl.aluOp)
      ADD: begin
        aluRes = opA + opB;
        // Same-sign operands, result sign flipped
        aluOvf = (opA[msb] == opB[msb]) && (aluRes[msb] != opA[msb]);
      end
      SUB: begin
        aluRes = opA - opB;
        aluOvf = (opA[msb] != opB[msb]) && (aluRes[msb] != opA[msb]);
      end
      XOR:     aluRes = opA ^ opB;
      AND:     aluRes = opA & opB;
      SLL:     aluRes = opA << opB[shWidth-1:0];
      SRL:     aluRes = opA >> opB[shWidth-1:0];
      LDI:     aluRes = idEx.imm;
      // Effective address, base plus offset
      LW, SW:  aluRes = opA + idEx.imm;
      default: aluRes = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////
  // Flag register, written at the end of EX
  assign writeZ  = idEx.ctrl.aluOp inside {ADD, SUB, XOR, AND, SLL, SRL};
  assign writeVn = idEx.ctrl.aluOp inside {ADD, SUB};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else begin
      if (writeZ) begin
        flags.z <= (aluRes == '0);
      end
      if (writeVn) begin
        flags.v <= aluOvf;
        flags.n <= aluRes[msb];
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // Branch resolution against stored flags
  always_comb begin
    case (idEx.cond)
      NE:      condMet = !flags.z;
      EQ:      condMet = flags.z;
      GT:      condMet = !flags.z && !flags.n;
      LT:      condMet = flags.n;
      GE:      condMet = flags.z || !flags.n;
      LE:      condMet = flags.n || flags.z;
      OV:      condMet = flags.v;
      default: condMet = 1'b1; // AL
    endcase
  end

  assign branchTaken  = idEx.ctrl.isBranch && condMet;
  assign branchTarget = idEx.pc + wordT'(2) + idEx.imm;

  // Next EX/MEM contents
  assign exOut = '{ctrl: idEx.ctrl, result: aluRes, storeData: opB, rd: idEx.rd};

  // Decoder and bubbles only ever hand over defined opcodes
  aluOpKnown: assert property (@(posedge clk) disable iff (!rstN)
    !$isunknown(idEx.ctrl.aluOp))
    else $error("Unknown aluOp in EX");

endmodule

//--- hazardUnit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module hazardUnit import cpuPkg::*; (
  input  idExT    idEx,
  input  exMemT   exMem,
  input  memWbT   memWb,
  // Source registers of the instruction in decode
  input  regAddrT decRs,
  input  regAddrT decRt,
  input  logic    branchTaken,
  output fwdSelE  fwdA,
  output fwdSelE  fwdB,
  output logic    stall,
  output logic    flush
);

  logic loadUse;

  // Newest producer wins, EX/MEM before MEM/WB
  // WB-to-decode is covered by the register file write-through
  function automatic fwdSelE pickSource(
    input regAddrT src,
    input exMemT   em,
    input memWbT   mw
  );
    if (em.ctrl.regWrite && (em.rd == src)) begin
      return EXMEM;
    end
    if (mw.ctrl.regWrite && (mw.rd == src)) begin
      return MEMWB;
    end
    return NONE;
  endfunction

  assign fwdA = pickSource(idEx.rs, exMem, memWb);
  assign fwdB = pickSource(idEx.rt, exMem, memWb);

  // Load in EX whose result decode needs next cycle
  assign loadUse = idEx.ctrl.memRead &&
                   ((idEx.rd == decRs) || (idEx.rd == decRt));

  always_comb begin
    stall = loadUse;
    flush = branchTaken;
    // A load and a branch never share ID/EX, so hold and clear never meet
    noHoldOnFlush: assert final (!(stall && flush))
      else $error("IF/ID asked to hold and clear in one cycle");
  end

endmodule

//--- instrDecoder.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module instrDecoder import cpuPkg::*; (
  input  wordT       instr,
  output ctrlT       ctrl,
  output regAddrT    rs,
  output regAddrT    rt,
  output regAddrT    rd,
  output wordT       imm,
  output branchCondE cond
);

  opcodeE op;

  assign op = opcodeE'(instr[15:12]);

  // Control bits per opcode
  always_comb begin
    ctrl = '0;
    case (op)
      ADD, SUB, XOR, AND, SLL, SRL: begin
        ctrl.aluOp    = op;
        ctrl.regWrite = 1'b1;
      end
      LDI: begin
        ctrl.aluOp    = LDI;
        ctrl.regWrite = 1'b1;
      end
      LW: begin
        ctrl.aluOp    = LW;
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b1;
      end
      SW: begin
        ctrl.aluOp    = SW;
        ctrl.memWrite = 1'b1;
      end
      B: begin
        ctrl.aluOp    = B;
        ctrl.isBranch = 1'b1;
      end
      HLT: begin
        ctrl.aluOp = HLT;
        ctrl.halt  = 1'b1;
      end
      // NOP and unused codes, all zero
      default: ;
    endcase
  end

  // Register fields
  assign rd = instr[11:8];
  assign rs = instr[7:4];
  // SW stores rd, so it goes out on the second read port
  assign rt = (op == SW) ? instr[11:8] : instr[3:0];

  assign cond = branchCondE'(instr[11:9]);

  // Sign extension by format
  always_comb begin
    case (op)
      LDI:     imm = {{8{instr[7]}}, instr[7:0]};
      LW, SW:  imm = {{12{instr[3]}}, instr[3:0]};
      // Branch offset in words, doubled to bytes
      B:       imm = {{6{instr[8]}}, instr[8:0], 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

//--- regFile.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module regFile import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  // Decode read ports
  input  regAddrT rdAddrA,
  input  regAddrT rdAddrB,
  output wordT    rdDataA,
  output wordT    rdDataB,
  // Write port from WB
  input  logic    wrEn,
  input  regAddrT wrAddr,
  input  wordT    wrData,
  // Debug read
  input  regAddrT dbgAddr,
  output wordT    dbgData
);

  wordT regs [`CPU_REG_COUNT];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Write-through
  // WB value shows up in decode in the same cycle
  assign rdDataA = (wrEn && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
  assign rdDataB = (wrEn && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

  // Plain array view for the debug port
  assign dbgData = regs[dbgAddr];

endmodule

//--- memBank.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module memBank import cpuPkg::*; #(
  parameter int depth = 256
) (
  input  logic clk,
  input  logic wrEn,
  input  wordT addr,
  input  wordT wrData,
  output wordT rdData
);

  localparam int idxWidth = $clog2(depth);

  wordT mem [depth];
  logic [idxWidth-1:0] idx;

  // Word index, upper address bits dropped
  assign idx = addr[idxWidth-1:0];

  // Write on the edge
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[idx] <= wrData;
    end
  end

  // Read is asynchronous, same cycle as address
  assign rdData = mem[idx];

  // Stores and program loads must land inside the array
  wrInRange: assert property (@(posedge clk) wrEn |-> (addr < depth))
    else $error("memBank write outside %0d words, addr %h", depth, addr);

endmodule

//--- cpuPkg.sv
`include "cpu_defines.svh"

package cpuPkg;

  typedef logic [`CPU_DATA_WIDTH-1:0] wordT;
  typedef logic [`CPU_REG_ADDR_WIDTH-1:0] regAddrT;

  // Opcode in instr[15:12]
  // All-zero word is NOP so cleared pipeline registers are bubbles
  typedef enum logic [`CPU_OPCODE_WIDTH-1:0] {
    NOP = 4'b0000,
    ADD = 4'b0001,
    SUB = 4'b0010,
    XOR = 4'b0011,
    AND = 4'b0100,
    SLL = 4'b0101,
    SRL = 4'b0110,
    LDI = 4'b0111,
    LW  = 4'b1000,
    SW  = 4'b1001,
    B   = 4'b1100,
    HLT = 4'b1111
  } opcodeE;

  // Branch condition in instr[11:9]
  typedef enum logic [`CPU_COND_WIDTH-1:0] {
    NE = 3'b000,
    EQ = 3'b001,
    GT = 3'b010,
    LT = 3'b011,
    GE = 3'b100,
    LE = 3'b101,
    OV = 3'b110,
    AL = 3'b111
  } branchCondE;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flagsT;

  typedef struct packed {
    opcodeE aluOp;
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    logic   memToReg;
    logic   isBranch;
    logic   halt;
  } ctrlT;

  typedef struct packed {
    wordT pc;
    wordT instr;
  } ifIdT;

  typedef struct packed {
    ctrlT       ctrl;
    wordT       pc;
    wordT       rsData;
    wordT       rtData;
    wordT       imm;
    regAddrT    rs;
    regAddrT    rt;
    regAddrT    rd;
    branchCondE cond;
  } idExT;

  typedef struct packed {
    ctrlT    ctrl;
    wordT    result;
    wordT    storeData;
    regAddrT rd;
  } exMemT;

  typedef struct packed {
    ctrlT    ctrl;
    wordT    result;
    wordT    loadData;
    regAddrT rd;
  } memWbT;

  // Operand source for EX
  typedef enum logic [1:0] {
    NONE  = 2'd0,
    EXMEM = 2'd1,
    MEMWB = 2'd2
  } fwdSelE;

endpackage

//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath word width
`define CPU_DATA_WIDTH 16

// Memory sizes, in words
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

// Register file size and register number width
`define CPU_REG_COUNT 16
`define CPU_REG_ADDR_WIDTH 4

// Instruction field widths
`define CPU_OPCODE_WIDTH 4
`define CPU_COND_WIDTH 3

`endif
